//--- verilog/cl_dram_pkg.sv
/*
 * shared sizes and status bus types for the dram status path
 * register index width is derived from STAT_REG_DEPTH, which must be a power of two
 */

package cl_dram_pkg;

   // ----------------------------------------------------------
   // structure
   // ----------------------------------------------------------

   // ddr channels a, b and d
   localparam int NUM_DDR_CHAN    = 3;

   // retiming depth on the way to and from the ddr controller
   localparam int STAT_CFG_STAGES = 8;

   // branch pipe depth on the status reset
   localparam int RST_PIPE_STAGES = 4;

   // ----------------------------------------------------------
   // status bus widths
   // ----------------------------------------------------------

   localparam int STAT_ADDR_W     = 8;
   localparam int STAT_DATA_W     = 32;
   localparam int STAT_INT_W      = 8;

   // register file per channel, decoded from the low address bits
   localparam int STAT_REG_DEPTH  = 16;
   localparam int STAT_IDX_W      = $clog2(STAT_REG_DEPTH);

   // ----------------------------------------------------------
   // status bus payloads
   // ----------------------------------------------------------

   // request toward the controller, 42 bits
   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [STAT_ADDR_W-1:0] addr;
      logic [STAT_DATA_W-1:0] wdata;
   } stat_req_t;

   // response back from the controller, 41 bits
   typedef struct packed {
      logic                   ack;
      logic [STAT_INT_W-1:0]  intr;
      logic [STAT_DATA_W-1:0] rdata;
   } stat_ack_t;

endpackage

//--- verilog/lib_pipe.sv
/*
 * plain register pipeline, STAGES must be 1 or more
 * every stage clears to zero on a synchronous low rst_n
 */
`timescale 1ns/1ps

module lib_pipe #(
   parameter type payload_t = logic,
   parameter int  STAGES    = 1
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  payload_t in_bus,
   output payload_t out_bus
);

   payload_t stage_q [STAGES];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
            stage_q[i] <= '0;
      end
      else
      begin
         stage_q[0] <= in_bus;
         // shift toward the output end
         for (int i = 1; i < STAGES; i++)
            stage_q[i] <= stage_q[i-1];
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule

//--- verilog/rst_sync.sv
/*
 * two-flop reset synchronizer followed by the status branch pipe
 * stat_rst_n releases 2 + RST_PIPE_STAGES cycles after pipe_rst_n goes high
 */
`timescale 1ns/1ps

module rst_sync
   import cl_dram_pkg::*;
(
   input  logic clk,
   input  logic pipe_rst_n,
   output logic stat_rst_n
);

   logic pre_sync_rst_n;
   logic sync_rst_n;

   // ----------------------------------------------------------
   // synchronizer
   // ----------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end
   end

   // ----------------------------------------------------------
   // branch pipe toward the status logic
   // ----------------------------------------------------------

   // free-running, so it carries the low level while sync_rst_n is held
   lib_pipe #(
      .payload_t (logic),
      .STAGES    (RST_PIPE_STAGES)
   ) STAT_SLC_RST_N (
      .clk     (clk),
      .rst_n   (1'b1),
      .in_bus  (sync_rst_n),
      .out_bus (stat_rst_n)
   );

endmodule

//--- verilog/ddr_stat_regs.sv
/*
 * status register block of one ddr controller, only addr[3:0] decodes
 * wr wins over rd; each request is acked one cycle after it is sampled
 */
`timescale 1ns/1ps

module ddr_stat_regs
   import cl_dram_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  stat_req_t req,
   output stat_ack_t rsp
);

   logic [STAT_DATA_W-1:0] regs [STAT_REG_DEPTH];
   logic [STAT_IDX_W-1:0]  idx;
   logic                   is_wr;
   logic                   is_rd;
   logic [STAT_INT_W-1:0]  intr_nxt;
   stat_ack_t              rsp_nxt;

   // upper address bits alias onto the same register
   assign idx   = req.addr[STAT_IDX_W-1:0];
   assign is_wr = req.wr;
   assign is_rd = req.rd & ~req.wr;

   // ----------------------------------------------------------
   // response build
   // ----------------------------------------------------------

   // interrupt byte as register 0 stands once this edge has passed
   always_comb
   begin
      if (is_wr && (idx == '0))
         intr_nxt = req.wdata[STAT_INT_W-1:0];
      else
         intr_nxt = regs[0][STAT_INT_W-1:0];
   end

   always_comb
   begin
      rsp_nxt = '0;
      if (is_wr || is_rd)
      begin
         rsp_nxt.ack  = 1'b1;
         rsp_nxt.intr = intr_nxt;
         // writes return zero data
         if (is_rd)
            rsp_nxt.rdata = regs[idx];
      end
   end

   // ----------------------------------------------------------
   // register file and response flop
   // ----------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < STAT_REG_DEPTH; i++)
            regs[i] <= '0;
      end
      else if (is_wr)
      begin
         regs[idx] <= req.wdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rsp <= '0;
      else
         rsp <= rsp_nxt;
   end

endmodule

//--- verilog/ddr_stat_chan.sv
/*
 * one ddr status channel with retiming on both directions
 * round trip is 2 * STAT_CFG_STAGES + 1 register stages, acks keep request order
 */
`timescale 1ns/1ps

module ddr_stat_chan
   import cl_dram_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  stat_req_t req,
   output stat_ack_t rsp
);

   // request and response at the controller side of the pipes
   stat_req_t req_q;
   stat_ack_t rsp_q;

   // ----------------------------------------------------------
   // request retiming
   // ----------------------------------------------------------

   lib_pipe #(
      .payload_t (stat_req_t),
      .STAGES    (STAT_CFG_STAGES)
   ) PIPE_DDR_STAT (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_bus  (req),
      .out_bus (req_q)
   );

   // controller status port
   ddr_stat_regs DDR_STAT_REGS (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req_q),
      .rsp   (rsp_q)
   );

   // ----------------------------------------------------------
   // acknowledge retiming
   // ----------------------------------------------------------

   lib_pipe #(
      .payload_t (stat_ack_t),
      .STAGES    (STAT_CFG_STAGES)
   ) PIPE_DDR_STAT_ACK (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_bus  (rsp_q),
      .out_bus (rsp)
   );

endmodule

//--- verilog/cl_dram_stat.sv
/*
 * status and configuration path of the dram card logic, one status bus per ddr channel
 * requests issued before the status reset releases are dropped; there is no back-pressure
 */
`timescale 1ns/1ps

module cl_dram_stat
   import cl_dram_pkg::*;
(
   input  logic      clk,
   input  logic      pipe_rst_n,
   input  stat_req_t stat_req [NUM_DDR_CHAN],
   output stat_ack_t stat_ack [NUM_DDR_CHAN]
);

   logic stat_rst_n;

   // ----------------------------------------------------------
   // reset tree
   // ----------------------------------------------------------

   rst_sync RST_SYNC (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .stat_rst_n (stat_rst_n)
   );

   // ----------------------------------------------------------
   // status channels
   // ----------------------------------------------------------

   // index 0, 1, 2 map to ddr a, b, d
   for (genvar ch = 0; ch < NUM_DDR_CHAN; ch++)
   begin : g_chan
      ddr_stat_chan DDR_STAT_CHAN (
         .clk   (clk),
         .rst_n (stat_rst_n),
         .req   (stat_req[ch]),
         .rsp   (stat_ack[ch])
      );
   end

endmodule

//--- verif/tb_cl_dram_stat.sv
/*
 * self-checking testbench for the dram status path, all three channels driven at once
 * expected acks come from a register model and are due a fixed round trip after issue
 */
`timescale 1ns/1ps

module tb_cl_dram_stat
   import cl_dram_pkg::*;
;

   localparam int CLK_HALF        = 20;
   localparam int RST_CYCLES      = 16;
   localparam int IDLE_CYCLES     = 12;
   localparam int DIRECTED_CYCLES = 80;
   localparam int B2B_CYCLES      = 64;
   localparam int MIX_REQS        = 600;

   // request path, register block, acknowledge path
   localparam int ROUND_TRIP      = 2 * STAT_CFG_STAGES + 1;

   localparam int WATCHDOG_CYCLES = RST_CYCLES + IDLE_CYCLES + DIRECTED_CYCLES + B2B_CYCLES
                                    + MIX_REQS + ROUND_TRIP + 200;

   localparam logic [31:0] SEED   = 32'he5921020;

   // one expected response, readable after edge number due
   typedef struct packed {
      int        due;
      int        ch;
      stat_ack_t ack;
   } pend_t;

   logic      clk;
   logic      pipe_rst_n;
   stat_req_t stat_req [NUM_DDR_CHAN];
   stat_ack_t stat_ack [NUM_DDR_CHAN];

   stat_req_t              next_req   [NUM_DDR_CHAN];
   logic [STAT_DATA_W-1:0] model_regs [NUM_DDR_CHAN][STAT_REG_DEPTH];
   pend_t                  pend_q     [$];
   logic [31:0]            rng_state;
   int                     edge_cnt;

   cl_dram_stat UUT (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .stat_req   (stat_req),
      .stat_ack   (stat_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_HALF) clk = ~clk;
   end

   // ----------------------------------------------------------
   // random source and register model
   // ----------------------------------------------------------

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic stat_req_t build_req(input logic wr, input logic rd,
                                           input logic [STAT_ADDR_W-1:0] addr,
                                           input logic [STAT_DATA_W-1:0] data);
      stat_req_t req;
      req.wr    = wr;
      req.rd    = rd;
      req.addr  = addr;
      req.wdata = data;
      return req;
   endfunction

   function automatic stat_req_t random_req();
      logic [31:0] r;
      stat_req_t   req;
      r   = next_random();
      req = '0;
      // mostly plain reads and writes, now and then both strobes
      case (r[2:0])
         3'd0, 3'd1, 3'd2:
            req.wr = 1'b1;
         3'd7:
         begin
            req.wr = 1'b1;
            req.rd = 1'b1;
         end
         default:
            req.rd = 1'b1;
      endcase
      req.addr  = r[STAT_ADDR_W+7:8];
      req.wdata = next_random();
      return req;
   endfunction

   // applies one request to the model and returns the response it must produce
   task automatic model_request(input int ch, input stat_req_t req, output stat_ack_t rsp);
      int idx;
      idx = int'(req.addr[STAT_IDX_W-1:0]);
      rsp = '0;
      rsp.ack = 1'b1;
      if (req.wr)
         model_regs[ch][idx] = req.wdata;
      else
         rsp.rdata = model_regs[ch][idx];
      // register 0 as it stands after this request
      rsp.intr = model_regs[ch][0][STAT_INT_W-1:0];
   endtask

   // ----------------------------------------------------------
   // checks
   // ----------------------------------------------------------

   task automatic check_ack(input string name, input stat_ack_t exp, input stat_ack_t act);
      if (act !== exp)
      begin
         $display("CHECK FAILED at %0t: %s expected ack=%b intr=%h rdata=%h %s",
                  $time, name, exp.ack, exp.intr, exp.rdata,
                  $sformatf("actual ack=%b intr=%h rdata=%h", act.ack, act.intr, act.rdata));
         $display("sim failed");
         $fatal(1, "stat_ack mismatch");
      end
   endtask

   // ----------------------------------------------------------
   // cycle driver
   // ----------------------------------------------------------

   task automatic issue(input int ch, input stat_req_t req);
      next_req[ch] = req;
   endtask

   // drives the queued requests after a rising edge, then checks at the falling edge
   task automatic step();
      stat_ack_t exp_now [NUM_DDR_CHAN];
      stat_ack_t rsp;
      pend_t     ent;
      @(posedge clk);
      edge_cnt++;
      for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
      begin
         stat_req[ch] <= next_req[ch];
         if (next_req[ch].wr || next_req[ch].rd)
         begin
            model_request(ch, next_req[ch], rsp);
            ent.due = edge_cnt + ROUND_TRIP;
            ent.ch  = ch;
            ent.ack = rsp;
            pend_q.push_back(ent);
         end
         next_req[ch] = '0;
      end
      @(negedge clk);
      for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         exp_now[ch] = '0;
      while (pend_q.size() > 0 && pend_q[0].due == edge_cnt)
      begin
         ent = pend_q.pop_front();
         exp_now[ent.ch] = ent.ack;
      end
      for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         check_ack($sformatf("stat_ack[%0d]", ch), exp_now[ch], stat_ack[ch]);
   endtask

   task automatic idle(input int n);
      repeat (n) step();
   endtask

   // ----------------------------------------------------------
   // tests
   // ----------------------------------------------------------

   // fill every register through an aliased address, read back through another
   task automatic alias_readback();
      logic [31:0] r;
      for (int i = 0; i < STAT_REG_DEPTH; i++)
      begin
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         begin
            r = next_random();
            issue(ch, build_req(1'b1, 1'b0, {r[STAT_ADDR_W-STAT_IDX_W-1:0], STAT_IDX_W'(i)},
                                next_random()));
         end
         step();
      end
      idle(3);
      for (int i = 0; i < STAT_REG_DEPTH; i++)
      begin
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         begin
            r = next_random();
            issue(ch, build_req(1'b0, 1'b1, {r[STAT_ADDR_W-STAT_IDX_W-1:0], STAT_IDX_W'(i)},
                                '0));
         end
         step();
      end
   endtask

   // same register with different contents per channel
   task automatic channel_isolation();
      for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         issue(ch, build_req(1'b1, 1'b0, 8'h0a, 32'h1111_1111 * (ch + 1)));
      step();
      // ch 1 only through an alias
      issue(1, build_req(1'b1, 1'b0, 8'h1a, next_random()));
      step();
      for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         issue(ch, build_req(1'b0, 1'b1, 8'h0a, '0));
      step();
      idle(2);
   endtask

   // register 0 drives intr; dual strobes behave as writes
   task automatic intr_and_dual_strobe();
      logic [31:0] r;
      repeat (8)
      begin
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         begin
            r = next_random();
            issue(ch, build_req(1'b1, 1'b0, {r[STAT_ADDR_W-1:STAT_IDX_W], STAT_IDX_W'(0)},
                                next_random()));
         end
         step();
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         begin
            r = next_random();
            issue(ch, build_req(1'b1, 1'b1, r[STAT_ADDR_W-1:0], next_random()));
         end
         step();
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         begin
            r = next_random();
            issue(ch, build_req(1'b0, 1'b1, r[STAT_ADDR_W-1:0], '0));
         end
         step();
      end
   endtask

   task automatic back_to_back_burst();
      repeat (B2B_CYCLES)
      begin
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
            issue(ch, random_req());
         step();
      end
   endtask

   // one channel always busy, the others about half the time
   task automatic random_mix();
      logic [31:0] r;
      int          sent;
      int          forced;
      sent = 0;
      while (sent < MIX_REQS)
      begin
         r      = next_random();
         forced = int'(r[15:0]) % NUM_DDR_CHAN;
         for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
         begin
            if (sent < MIX_REQS && (ch == forced || r[16 + ch]))
            begin
               issue(ch, random_req());
               sent++;
            end
         end
         step();
      end
   endtask

   // ----------------------------------------------------------
   // main sequence and watchdog
   // ----------------------------------------------------------

   initial
   begin
      rng_state  = SEED;
      edge_cnt   = 0;
      pipe_rst_n <= 1'b0;
      for (int ch = 0; ch < NUM_DDR_CHAN; ch++)
      begin
         stat_req[ch] <= '0;
         next_req[ch] = '0;
         for (int i = 0; i < STAT_REG_DEPTH; i++)
            model_regs[ch][i] = '0;
      end
      repeat (RST_CYCLES) @(posedge clk);
      pipe_rst_n <= 1'b1;
      // quiet outputs while the status reset releases
      idle(IDLE_CYCLES);
      alias_readback();
      channel_isolation();
      intr_and_dual_strobe();
      back_to_back_burst();
      random_mix();
      while (pend_q.size() > 0)
         step();
      idle(2);
      $display("sim passed");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: acks still pending");
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- vlog.f
verilog/cl_dram_pkg.sv
verilog/lib_pipe.sv
verilog/rst_sync.sv
verilog/ddr_stat_regs.sv
verilog/ddr_stat_chan.sv
verilog/cl_dram_stat.sv
verif/tb_cl_dram_stat.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# a $fatal in the run gives a non-zero exit status

cd "$(dirname "$0")" &&
verilator --binary -f vlog.f --top-module tb_cl_dram_stat -o tb_cl_dram_stat &&
./obj_dir/tb_cl_dram_stat || exit 1
